/* run_sim.sh */
#!/usr/bin/env bash
# Builds the decoder testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_pcs_rx_decoder -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation exited with an error status"
  exit 1
fi

cat sim.log
if grep -q "Verification failed" sim.log; then
  exit 1
fi
exit 0

/* testbench/decode_vectors.svh */
// Stimulus and expected decode table, included into the decoder testbench and loaded at start
// Columns: name, code group in wire order (j h g f i e d c b a), sync, byte, class, rd after
// Rows run in order from rd- after reset, so each row's form follows the rd the row above leaves

task automatic load_vectors();
  // --------------------
  // Data groups in the right form
  add_row("D0.0 rd-",              10'b0010111001, 1'b1, 8'h00, sym_data,        1'b0);
  add_row("D21.5 rd-",             10'b0101010101, 1'b1, 8'hb5, sym_data,        1'b0);
  add_row("D3.3 rd-",              10'b0011100011, 1'b1, 8'h63, sym_data,        1'b0);
  add_row("D28.7 rd-",             10'b0111011100, 1'b1, 8'hfc, sym_data,        1'b1);
  add_row("D17.7 rd+",             10'b1000110001, 1'b1, 8'hf1, sym_data,        1'b0);

  // --------------------
  // Control characters in the current form
  add_row("K28.5 rd-",             10'b0101111100, 1'b1, 8'hbc, sym_comma,       1'b1);
  add_row("K27.7 rd+",             10'b1110100100, 1'b1, 8'hfb, sym_sop,         1'b1);
  add_row("K29.7 rd+",             10'b1110100010, 1'b1, 8'hfd, sym_eop,         1'b1);
  add_row("K23.7 rd+",             10'b1110101000, 1'b1, 8'hf7, sym_carrier_ext, 1'b1);
  add_row("K30.7 rd+",             10'b1110100001, 1'b1, 8'hfe, sym_err_prop,    1'b1);
  add_row("K28.1 rd+",             10'b0110000011, 1'b1, 8'hbc, sym_comma,       1'b0);

  // --------------------
  // Wrong disparity form, with and without sync
  add_row("K28.5 rd+ form, sync",  10'b1010000011, 1'b1, 8'h00, sym_invalid,     1'b0);
  add_row("K28.5 rd+ form, async", 10'b1010000011, 1'b0, 8'hbc, sym_comma,       1'b0);
  add_row("D0.0 rd+ form, sync",   10'b1101000110, 1'b1, 8'h00, sym_invalid,     1'b1);
  add_row("D0.0 rd- form, async",  10'b0010111001, 1'b0, 8'h00, sym_invalid,     1'b0);

  // Patterns outside every table
  add_row("all zeros",             10'b0000000000, 1'b1, 8'h00, sym_invalid,     1'b0);
  add_row("all ones",              10'b1111111111, 1'b1, 8'h00, sym_invalid,     1'b1);
  add_row("111100 0000",           10'b0000001111, 1'b1, 8'h00, sym_invalid,     1'b0);

  // Alternate Dx.7 forms
  add_row("D17.7 alt rd-",         10'b1110110001, 1'b1, 8'hf1, sym_data,        1'b1);
  add_row("D11.7 alt rd+",         10'b0001001011, 1'b1, 8'heb, sym_data,        1'b0);
endtask

/* testbench/tb_pcs_rx_decoder.sv */
// Testbench for the receive code-group decoder, runs the vector table under random back-pressure
`timescale 1ns/10ps

module tb_pcs_rx_decoder;
  import pcs_code_pkg::*;
  import pcs_stream_pkg::*;

  localparam int wait_limit = 64;  // Cycles per handshake wait

  logic          clk;
  logic          rst_n;
  logic          in_valid;
  logic          in_ready;
  code_beat_t    in_beat;
  logic          out_valid;
  logic          out_ready;
  decoded_beat_t out_beat;

  // Vector table, filled by load_vectors
  string         row_name[$];
  code_group_t   row_code[$];
  logic          row_sync[$];
  decoded_beat_t row_expect[$];

  int            error_count   = 0;
  int            check_count   = 0;
  int            timeout_count = 0;
  logic [31:0]   rng_state     = 32'd49;  // xorshift seed
  logic          accept_pending;          // Accept seen at the previous negedge

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  pcs_rx_decoder pcs_rx_decoder_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_row(input string name, input code_group_t code, input logic sync,
                         input data_byte_t data, input sym_class_t sym, input logic disp);
    row_name.push_back(name);
    row_code.push_back(code);
    row_sync.push_back(sync);
    row_expect.push_back({data, sym, disp});
  endtask

  `include "decode_vectors.svh"

  task automatic check_value(input string test_name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("** Error: %s %s expected %0h actual %0h", test_name, field, expected, actual);
    end
  endtask

  // --------------------
  // Source side
  task automatic wait_for_accept(input int idx);
    int   waited;
    logic ready_seen;
    waited     = 0;
    ready_seen = 1'b0;
    while (!ready_seen && waited < wait_limit)
    begin
      @(negedge clk);
      ready_seen = in_ready;  // Stable until the next rising edge
      @(posedge clk);
      waited++;
    end
    if (!ready_seen)
    begin
      timeout_count++;
      $display("Timeout: input row %s was never accepted", row_name[idx]);
    end
  endtask

  task automatic drive_rows();
    for (int i = 0; i < row_name.size() && timeout_count == 0; i++)
    begin
      in_valid <= 1'b1;
      in_beat  <= {row_code[i], row_sync[i]};
      wait_for_accept(i);
    end
    in_valid <= 1'b0;
  endtask

  // --------------------
  // Sink side
  task automatic wait_for_output(input int idx, output logic seen);
    int waited;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < wait_limit)
    begin
      @(negedge clk);
      seen = out_valid && out_ready;  // Transfers on the next rising edge
      waited++;
    end
    if (!seen)
    begin
      timeout_count++;
      $display("Timeout: output beat for row %s never arrived", row_name[idx]);
    end
  endtask

  task automatic collect_rows();
    logic seen;
    for (int i = 0; i < row_name.size() && timeout_count == 0; i++)
    begin
      wait_for_output(i, seen);
      if (seen)
      begin
        check_value(row_name[i], "byte", 32'(row_expect[i].data), 32'(out_beat.data));
        check_value(row_name[i], "class", 32'(row_expect[i].sym_class), 32'(out_beat.sym_class));
        check_value(row_name[i], "disparity", 32'(row_expect[i].disp), 32'(out_beat.disp));
      end
    end
  endtask

  // Random back-pressure
  always @(posedge clk)
  begin
    rng_state  = xorshift32(rng_state);
    out_ready <= rng_state[0];
  end

  // Every accept leaves a beat in the register one cycle later
  always @(negedge clk)
  begin
    if (!rst_n)
      accept_pending = 1'b0;
    else
    begin
      if (accept_pending)
        check_value("accept latency", "out_valid", 32'd1, 32'(out_valid));
      accept_pending = in_valid && in_ready;
    end
  end

  task automatic finish_run();
    $display("Checks run: %0d, errors: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  endtask

  // --------------------
  // Main sequence
  initial
  begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    load_vectors();

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_value("after reset", "out_valid", 32'd0, 32'(out_valid));
    check_value("after reset", "in_ready", 32'd1, 32'(in_ready));

    @(posedge clk);
    fork
      drive_rows();
      collect_rows();
    join

    // Nothing may follow the last row
    if (timeout_count == 0)
    begin
      repeat (8)
      begin
        @(negedge clk);
        if (out_valid)
        begin
          error_count++;
          $display("Extra output beat seen after the last table row");
        end
      end
    end

    finish_run();
  end

endmodule

/* verilog.f */
+incdir+testbench
verilog/pcs_code_pkg.sv
verilog/pcs_stream_pkg.sv
verilog/sub_block_6b_decoder.sv
verilog/sub_block_4b_decoder.sv
verilog/control_code_decoder.sv
verilog/code_group_classifier.sv
verilog/rx_output_stage.sv
verilog/pcs_rx_decoder.sv
testbench/tb_pcs_rx_decoder.sv

/* verilog/code_group_classifier.sv */
// Joins the half lookups and the control match into one decoded beat, used by the decoder top
`timescale 1ns/10ps

module code_group_classifier (
  input  pcs_stream_pkg::six_info_t     six_info,
  input  pcs_stream_pkg::four_info_t    four_info,
  input  pcs_code_pkg::sym_class_t      ctrl_class,
  input  logic                          ctrl_match,
  input  logic                          ctrl_valid,
  input  logic                          rd,
  output pcs_stream_pkg::decoded_beat_t result
);
  import pcs_code_pkg::*;

  logic [1:0] sp6;
  logic [2:0] sp4;
  logic       six_ok;      // 6b form agrees with rd
  logic       four_ok;     // 4b form agrees with the 6b half
  logic       alt_rdn_ok;  // 0111 rules
  logic       alt_rdp_ok;  // 1000 rules
  logic       data_ok;
  logic       rd_mid;      // rd between the two halves
  logic       next_rd;
  data_byte_t ctrl_byte;

  always_comb
  begin
    sp6 = six_info.special;
    sp4 = four_info.special;

    // --------------------
    // Data validity
    six_ok  = six_info.valid & ((rd & six_info.flip_ok) == six_info.flipped);
    four_ok = four_info.valid &
              (sp4[1] | sp4[0] |
               ((four_info.flip_ok & (rd ^ six_info.rev4)) == four_info.flipped));
    alt_rdn_ok = (~sp4[1] & (~sp6[1] | rd | ~sp4[2])) |
                 (sp4[1] & sp6[1] & ~rd & sp4[2]);
    alt_rdp_ok = (~sp4[0] & (~sp6[0] | ~rd | ~sp4[2])) |
                 (sp4[0] & sp6[0] & rd & sp4[2]);
    data_ok = six_ok & four_ok & alt_rdn_ok & alt_rdp_ok;

    // --------------------
    // Running disparity, later half wins unless neutral
    rd_mid  = (six_info.disp == disp_pos) ? 1'b1 :
              (six_info.disp == disp_neg) ? 1'b0 : rd;
    next_rd = (four_info.disp == disp_pos) ? 1'b1 :
              (four_info.disp == disp_neg) ? 1'b0 : rd_mid;

    case (ctrl_class)
      sym_sop:         ctrl_byte = byte_sop;
      sym_eop:         ctrl_byte = byte_eop;
      sym_carrier_ext: ctrl_byte = byte_carrier;
      sym_comma:       ctrl_byte = byte_comma;
      sym_err_prop:    ctrl_byte = byte_err;
      default:         ctrl_byte = '0;
    endcase

    result.disp = next_rd;
    if (data_ok && !ctrl_match)
    begin
      result.sym_class = sym_data;
      result.data      = {four_info.dec3, six_info.dec5};  // HGF EDCBA
    end
    else if (ctrl_valid && !data_ok)
    begin
      result.sym_class = ctrl_class;
      result.data      = ctrl_byte;
    end
    else
    begin
      result.sym_class = sym_invalid;  // No match, both, or K in the wrong form
      result.data      = '0;
    end

    // A balanced 4b half of good data leaves rd where the 6b half put it
    assert (!(data_ok && four_info.disr) || next_rd == rd_mid)
      else $error("Balanced 4b half moved the running disparity");
  end

endmodule

/* verilog/control_code_decoder.sv */
// Matches the six control characters in both forms, instantiated once by the receive decoder top
`timescale 1ns/10ps

module control_code_decoder (
  input  pcs_code_pkg::code_group_t code,
  input  logic                      sync,
  input  logic                      rd,
  output pcs_code_pkg::sym_class_t  ctrl_class,
  output logic                      ctrl_match,
  output logic                      ctrl_valid
);
  import pcs_code_pkg::*;

  code_group_t chart;
  logic [4:0]  entry;     // {class, match, rd+ form}
  logic        pos_form;  // Pattern is the one sent at rd+

  assign chart = chart_order(code);

  always_comb
  begin
    case (chart)                                    // fghj_abcdei
      10'b1000_110110: entry = {sym_sop, 2'b10};          // K27.7
      10'b0111_001001: entry = {sym_sop, 2'b11};
      10'b1000_101110: entry = {sym_eop, 2'b10};          // K29.7
      10'b0111_010001: entry = {sym_eop, 2'b11};
      10'b1000_111010: entry = {sym_carrier_ext, 2'b10};  // K23.7
      10'b0111_000101: entry = {sym_carrier_ext, 2'b11};
      10'b1010_001111: entry = {sym_comma, 2'b10};        // K28.5
      10'b0101_110000: entry = {sym_comma, 2'b11};
      10'b1001_001111: entry = {sym_comma, 2'b10};        // K28.1
      10'b0110_110000: entry = {sym_comma, 2'b11};
      10'b1000_011110: entry = {sym_err_prop, 2'b10};     // K30.7
      10'b0111_100001: entry = {sym_err_prop, 2'b11};
      default:         entry = {sym_invalid, 2'b00};
    endcase

    ctrl_class = sym_class_t'(entry[4:2]);
    ctrl_match = entry[1];
    pos_form   = entry[0];

    // Before sync any form is taken, after sync the form must follow rd
    ctrl_valid = ctrl_match & (~sync | (pos_form == rd));
  end

endmodule

/* verilog/pcs_code_pkg.sv */
// Code-group constants, types and the chart reorder helper used by every receive decode module
package pcs_code_pkg;

  // --------------------
  // Widths
  localparam int code_width = 10;
  localparam int byte_width = 8;

  typedef logic [code_width-1:0] code_group_t;  // Wire order, bit 0 is chart bit a
  typedef logic [byte_width-1:0] data_byte_t;

  // Symbol class seen by the MAC, encoding is fixed
  typedef enum logic [2:0] {
    sym_sop         = 3'd0,  // /S/
    sym_invalid     = 3'd1,
    sym_eop         = 3'd2,  // /T/
    sym_carrier_ext = 3'd3,  // /R/
    sym_comma       = 3'd4,  // /K/
    sym_data        = 3'd5,  // /D/
    sym_err_prop    = 3'd7   // /V/
  } sym_class_t;

  // --------------------
  // Disparity
  typedef logic [1:0] disp_class_t;            // [1] leaves rd positive, [0] leaves rd negative
  localparam disp_class_t disp_neutral = 2'b00;
  localparam disp_class_t disp_neg     = 2'b01;
  localparam disp_class_t disp_pos     = 2'b10;
  localparam logic        rd_neg       = 1'b0;  // rd after reset

  // Fixed bytes of the control characters
  localparam data_byte_t byte_sop     = 8'hfb;
  localparam data_byte_t byte_eop     = 8'hfd;
  localparam data_byte_t byte_carrier = 8'hf7;
  localparam data_byte_t byte_comma   = 8'hbc;
  localparam data_byte_t byte_err     = 8'hfe;

  // Wire order to chart order, result is fghj in [9:6] and abcdei in [5:0]
  function automatic code_group_t chart_order(input code_group_t wire_cg);
    return {wire_cg[6], wire_cg[7], wire_cg[8], wire_cg[9],
            wire_cg[0], wire_cg[1], wire_cg[2], wire_cg[3], wire_cg[4], wire_cg[5]};
  endfunction

endpackage

/* verilog/pcs_rx_decoder.sv */
// Receive 1000BASE-X code-group decoder top that turns a code-group stream into decoded beats
`timescale 1ns/10ps

module pcs_rx_decoder (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  pcs_stream_pkg::code_beat_t    in_beat,
  output logic                          out_valid,
  input  logic                          out_ready,
  output pcs_stream_pkg::decoded_beat_t out_beat
);
  import pcs_code_pkg::*;
  import pcs_stream_pkg::*;

  six_info_t     six_info;    // abcdei lookup
  four_info_t    four_info;   // fghj lookup
  sym_class_t    ctrl_class;
  logic          ctrl_match;  // Any K pattern
  logic          ctrl_valid;  // K pattern that passed the rd check
  logic          rd;          // Running disparity from the output stage
  decoded_beat_t result;

  sub_block_6b_decoder sub_block_6b_decoder_inst (
    .code     (in_beat.code),
    .six_info (six_info)
  );

  sub_block_4b_decoder sub_block_4b_decoder_inst (
    .code      (in_beat.code),
    .four_info (four_info)
  );

  control_code_decoder control_code_decoder_inst (
    .code       (in_beat.code),
    .sync       (in_beat.sync),
    .rd         (rd),
    .ctrl_class (ctrl_class),
    .ctrl_match (ctrl_match),
    .ctrl_valid (ctrl_valid)
  );

  code_group_classifier code_group_classifier_inst (
    .six_info   (six_info),
    .four_info  (four_info),
    .ctrl_class (ctrl_class),
    .ctrl_match (ctrl_match),
    .ctrl_valid (ctrl_valid),
    .rd         (rd),
    .result     (result)
  );

  rx_output_stage rx_output_stage_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .result    (result),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat),
    .rd        (rd)
  );

endmodule

/* verilog/pcs_stream_pkg.sv */
// Beat and lookup-result structures passed between the receive decode stages
package pcs_stream_pkg;

  // --------------------
  // Stream beats
  typedef struct packed {
    pcs_code_pkg::code_group_t code;  // Raw code group in wire order
    logic                      sync;  // Link in sync so control groups get the rd check
  } code_beat_t;

  typedef struct packed {
    pcs_code_pkg::data_byte_t data;       // 00 when invalid
    pcs_code_pkg::sym_class_t sym_class;
    logic                     disp;       // rd after this code group, 1 is positive
  } decoded_beat_t;

  // --------------------
  // Half-symbol lookups
  typedef struct packed {
    logic [4:0]                dec5;     // EDCBA
    logic                      valid;    // Pattern is in the 6b table
    logic                      flip_ok;  // Pattern has two disparity forms
    logic                      flipped;  // This is the rd+ form
    logic                      rev4;     // 4b half picks its form from entry rd, not inverted
    logic [1:0]                special;  // May pair with the alternate Dx.7 ([1] rd-, [0] rd+)
    pcs_code_pkg::disp_class_t disp;
  } six_info_t;

  typedef struct packed {
    logic [2:0]                dec3;     // HGF
    logic                      valid;
    logic                      flip_ok;
    logic                      flipped;
    logic [2:0]                special;  // [2] any Dx.7, [1] 0111 alt, [0] 1000 alt
    logic                      disr;     // Balanced half, rd passes through
    pcs_code_pkg::disp_class_t disp;
  } four_info_t;

endpackage

/* verilog/rx_output_stage.sv */
// One-deep output register with the running disparity, instantiated once by the decoder top
`timescale 1ns/10ps

module rx_output_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  pcs_stream_pkg::decoded_beat_t result,
  output logic                          out_valid,
  input  logic                          out_ready,
  output pcs_stream_pkg::decoded_beat_t out_beat,
  output logic                          rd
);
  import pcs_code_pkg::*;

  logic accept;  // Code group taken this edge

  assign in_ready = ~out_valid | out_ready;  // Empty, or held beat leaves this edge
  assign accept   = in_valid & in_ready;

  // --------------------
  // Control state
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
      rd        <= rd_neg;
    end
    else
    begin
      if (accept)
      begin
        out_valid <= 1'b1;
        rd        <= result.disp;  // Next group is checked against this
      end
      else if (out_ready)
      begin
        out_valid <= 1'b0;
      end
    end
  end

  // Payload
  always_ff @(posedge clk)
  begin
    if (accept)
      out_beat <= result;
  end

  // Held beat must not move while the sink stalls
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("Output beat changed under back-pressure");

endmodule

/* verilog/sub_block_4b_decoder.sv */
// Looks up the fghj half of a code group, instantiated once by the receive decoder top
`timescale 1ns/10ps

module sub_block_4b_decoder (
  input  pcs_code_pkg::code_group_t   code,
  output pcs_stream_pkg::four_info_t  four_info
);
  import pcs_code_pkg::*;

  code_group_t chart;
  logic [9:0]  entry;   // {dec3, valid, flip_ok, flipped, special, disr}

  assign chart = chart_order(code);

  always_comb
  begin
    case (chart[9:6])
      4'b1011: entry = {3'd0, 7'b1_11_000_0};  // Dx.0
      4'b0100: entry = {3'd0, 7'b1_10_000_0};
      4'b1001: entry = {3'd1, 7'b1_00_000_1};
      4'b0101: entry = {3'd2, 7'b1_00_000_1};
      4'b0011: entry = {3'd3, 7'b1_10_000_1};  // Dx.3 two balanced forms
      4'b1100: entry = {3'd3, 7'b1_11_000_1};
      4'b0010: entry = {3'd4, 7'b1_10_000_0};
      4'b1101: entry = {3'd4, 7'b1_11_000_0};
      4'b1010: entry = {3'd5, 7'b1_00_000_1};
      4'b0110: entry = {3'd6, 7'b1_00_000_1};
      4'b0001: entry = {3'd7, 7'b1_10_100_0};  // Primary Dx.7
      4'b1110: entry = {3'd7, 7'b1_11_100_0};
      4'b0111: entry = {3'd7, 7'b1_00_110_0};  // Alternate Dx.7 at rd-
      4'b1000: entry = {3'd7, 7'b1_00_101_0};  // Alternate Dx.7 at rd+
      default: entry = '0;                     // 0000 and 1111
    endcase

    {four_info.dec3, four_info.valid, four_info.flip_ok,
     four_info.flipped, four_info.special, four_info.disr} = entry;

    // 0011 and 1100 set rd even though balanced
    if (chart[9:6] == 4'b0011)
      four_info.disp = disp_pos;
    else if (chart[9:6] == 4'b1100)
      four_info.disp = disp_neg;
    else if ($countones(chart[9:6]) > 2)
      four_info.disp = disp_pos;
    else if ($countones(chart[9:6]) < 2)
      four_info.disp = disp_neg;
    else
      four_info.disp = disp_neutral;
  end

endmodule

/* verilog/sub_block_6b_decoder.sv */
// Looks up the abcdei half of a code group, instantiated once by the receive decoder top
`timescale 1ns/10ps

module sub_block_6b_decoder (
  input  pcs_code_pkg::code_group_t  code,
  output pcs_stream_pkg::six_info_t  six_info
);
  import pcs_code_pkg::*;

  code_group_t chart;   // Chart order, 6b half in [5:0]
  logic [10:0] entry;   // {dec5, valid, flip_ok, flipped, rev4, special}

  assign chart = chart_order(code);

  always_comb
  begin
    case (chart[5:0])
      6'b100111: entry = {5'd0, 6'b1_10_0_00};   // D0 rd-
      6'b011000: entry = {5'd0, 6'b1_11_0_00};   // D0 rd+
      6'b011101: entry = {5'd1, 6'b1_10_0_00};
      6'b100010: entry = {5'd1, 6'b1_11_0_00};
      6'b101101: entry = {5'd2, 6'b1_10_0_00};
      6'b010010: entry = {5'd2, 6'b1_11_0_00};
      6'b110001: entry = {5'd3, 6'b1_00_1_00};   // Balanced, one form
      6'b110101: entry = {5'd4, 6'b1_10_0_00};
      6'b001010: entry = {5'd4, 6'b1_11_0_00};
      6'b101001: entry = {5'd5, 6'b1_00_1_00};
      6'b011001: entry = {5'd6, 6'b1_00_1_00};
      6'b111000: entry = {5'd7, 6'b1_10_1_00};   // D7 keeps rd- though balanced
      6'b000111: entry = {5'd7, 6'b1_11_1_00};
      6'b111001: entry = {5'd8, 6'b1_10_0_00};
      6'b000110: entry = {5'd8, 6'b1_11_0_00};
      6'b100101: entry = {5'd9, 6'b1_00_1_00};
      6'b010101: entry = {5'd10, 6'b1_00_1_00};
      6'b110100: entry = {5'd11, 6'b1_00_1_01};  // Takes 1000 alt at rd+
      6'b001101: entry = {5'd12, 6'b1_00_1_00};
      6'b101100: entry = {5'd13, 6'b1_00_1_01};
      6'b011100: entry = {5'd14, 6'b1_00_1_01};
      6'b010111: entry = {5'd15, 6'b1_10_0_00};
      6'b101000: entry = {5'd15, 6'b1_11_0_00};
      6'b011011: entry = {5'd16, 6'b1_10_0_00};
      6'b100100: entry = {5'd16, 6'b1_11_0_00};
      6'b100011: entry = {5'd17, 6'b1_00_1_10};  // Takes 0111 alt at rd-
      6'b010011: entry = {5'd18, 6'b1_00_1_10};
      6'b110010: entry = {5'd19, 6'b1_00_1_00};
      6'b001011: entry = {5'd20, 6'b1_00_1_10};
      6'b101010: entry = {5'd21, 6'b1_00_1_00};
      6'b011010: entry = {5'd22, 6'b1_00_1_00};
      6'b111010: entry = {5'd23, 6'b1_10_0_00};
      6'b000101: entry = {5'd23, 6'b1_11_0_00};
      6'b110011: entry = {5'd24, 6'b1_10_0_00};
      6'b001100: entry = {5'd24, 6'b1_11_0_00};
      6'b100110: entry = {5'd25, 6'b1_00_1_00};
      6'b010110: entry = {5'd26, 6'b1_00_1_00};
      6'b110110: entry = {5'd27, 6'b1_10_0_00};
      6'b001001: entry = {5'd27, 6'b1_11_0_00};
      6'b001110: entry = {5'd28, 6'b1_00_1_00};  // K28 halves are not here
      6'b101110: entry = {5'd29, 6'b1_10_0_00};
      6'b010001: entry = {5'd29, 6'b1_11_0_00};
      6'b011110: entry = {5'd30, 6'b1_10_0_00};
      6'b100001: entry = {5'd30, 6'b1_11_0_00};
      6'b101011: entry = {5'd31, 6'b1_10_0_00};
      6'b010100: entry = {5'd31, 6'b1_11_0_00};
      default:   entry = '0;                     // Not a data half
    endcase

    {six_info.dec5, six_info.valid, six_info.flip_ok,
     six_info.flipped, six_info.rev4, six_info.special} = entry;

    // Disparity class from the ones count
    if (chart[5:0] == 6'b000111)
      six_info.disp = disp_pos;                  // Balanced but ends on a run of ones
    else if (chart[5:0] == 6'b111000)
      six_info.disp = disp_neg;
    else if ($countones(chart[5:0]) > 3)
      six_info.disp = disp_pos;
    else if ($countones(chart[5:0]) < 3)
      six_info.disp = disp_neg;
    else
      six_info.disp = disp_neutral;

    // A half can pair with one alternate Dx.7 form only
    assert (!(six_info.valid && six_info.special == 2'b11))
      else $error("6b half flagged for both alternate Dx.7 forms");
  end

endmodule
